// File: tb.f
common/cpu_pkg.sv
common/id_ex_if.sv
common/wb_if.sv
src/fetch_unit.sv
decode/decode.sv
execute/execute.sv
src/mem_stage.sv
src/hazard_fsm.sv
src/cpu.sv
bench/tb_cpu.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - common/cpu_pkg.sv
  - common/id_ex_if.sv
  - common/wb_if.sv
  - src/fetch_unit.sv
  - decode/decode.sv
  - execute/execute.sv
  - src/mem_stage.sv
  - src/hazard_fsm.sv
  - src/cpu.sv
  - target: simulation
    files:
      - bench/tb_cpu.sv

// File: bench/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;
	import cpu_pkg::*;

	localparam int IMEM_AW      = 8;
	localparam int DMEM_AW      = 8;
	localparam int MAX_TESTS    = 8;
	localparam int PROG_WORDS   = 16;
	localparam int MAX_WRITES   = 8;
	localparam int RESET_CYCLES = 5;
	// Cycles watched after hlt rises
	localparam int HOLD_CYCLES  = 6;

	logic               clk = 1'b0;
	logic               reset;
	logic               prog_we;
	logic [IMEM_AW-1:0] prog_addr;
	data_t              prog_data;
	logic               hlt;
	data_t              pc;
	logic               wb_we;
	reg_addr_t          wb_dst;
	data_t              wb_data;

	//////////////////////////////////////////////////
	// Test table, one row per test

	string     test_name  [MAX_TESTS];
	data_t     prog_mem   [MAX_TESTS*PROG_WORDS];
	reg_addr_t exp_dst    [MAX_TESTS*MAX_WRITES];
	data_t     exp_data   [MAX_TESTS*MAX_WRITES];
	int        write_cnt  [MAX_TESTS];
	data_t     exp_hlt_pc [MAX_TESTS];
	int        num_tests = 0;
	int        word_cnt  = 0;

	string     cur_name      = "none";
	int        value_errors  = 0;
	int        order_errors  = 0;
	int        other_errors  = 0;
	int        cycle_count   = 0;
	int        timeout_limit = 0;
	// Hazard machine state, shown on timeout
	hz_state_e hz_state;

	cpu #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) DUT (
		.clk(clk), .reset(reset),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.hlt(hlt), .pc(pc),
		.wb_we(wb_we), .wb_dst(wb_dst), .wb_data(wb_data)
	);

	assign hz_state = DUT.hazard_unit.state;

	// 40 ns clock
	always #20 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			$display("ERROR: timeout after %0d cycles in test %s, hazard state %s",
				cycle_count, cur_name, hz_state.name());
			$display(">>> FAIL");
			$finish;
		end
	end

	// Instruction encodings
	function automatic data_t reg_form(opcode_e op, reg_addr_t rd, reg_addr_t rs,
		reg_addr_t rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic data_t imm_form(opcode_e op, reg_addr_t rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	// Opens a row, unused words hold HLT
	task automatic new_test(input string name, input data_t hlt_pc);
		int i;
		test_name[num_tests]  = name;
		exp_hlt_pc[num_tests] = hlt_pc;
		write_cnt[num_tests]  = 0;
		for (i = 0; i < PROG_WORDS; i++)
			prog_mem[num_tests*PROG_WORDS + i] = reg_form(HLT, 0, 0, 0);
		word_cnt = 0;
		timeout_limit += 20 + 3*PROG_WORDS;
		num_tests++;
	endtask

	task automatic add_word(input data_t w);
		prog_mem[(num_tests-1)*PROG_WORDS + word_cnt] = w;
		word_cnt++;
	endtask

	task automatic expect_write(input reg_addr_t dst, input data_t data);
		int idx;
		idx = (num_tests-1)*MAX_WRITES + write_cnt[num_tests-1];
		exp_dst[idx]  = dst;
		exp_data[idx] = data;
		write_cnt[num_tests-1]++;
	endtask

	task automatic build_table();
		// Back-to-back ALU chain, mem and wb forwarding
		new_test("alu_forward", 16'd5);
		add_word(imm_form(LLB, 1, 8'h05));
		add_word(imm_form(LLB, 2, 8'hFD));
		add_word(reg_form(ADD, 3, 1, 2));
		add_word(reg_form(SUB, 4, 3, 1));
		add_word(reg_form(AND, 5, 4, 3));
		expect_write(1, 16'h0005);
		expect_write(2, 16'hFFFD);
		expect_write(3, 16'h0002);
		expect_write(4, 16'hFFFD);
		expect_write(5, 16'h0000);
		// Store, load at base 0x40 offset 3, then load-use
		new_test("store_load", 16'd6);
		add_word(imm_form(LLB, 1, 8'h12));
		add_word(imm_form(LLB, 2, 8'h40));
		add_word(reg_form(SW, 1, 2, 3));
		add_word(reg_form(LW, 6, 2, 3));
		add_word(reg_form(ADD, 7, 6, 1));
		add_word(reg_form(SUB, 8, 7, 6));
		expect_write(1, 16'h0012);
		expect_write(2, 16'h0040);
		expect_write(6, 16'h0012);
		expect_write(7, 16'h0024);
		expect_write(8, 16'h0012);
		// Not taken at 2, taken at 4 to 7
		new_test("branch", 16'd8);
		add_word(imm_form(LLB, 1, 8'h00));
		add_word(imm_form(LLB, 2, 8'h01));
		add_word(imm_form(BEQZ, 2, 8'd5));
		add_word(imm_form(LLB, 9, 8'h44));
		add_word(imm_form(BEQZ, 1, 8'd2));
		add_word(imm_form(LLB, 3, 8'h11));
		add_word(imm_form(LLB, 4, 8'h22));
		add_word(imm_form(LLB, 5, 8'h33));
		expect_write(1, 16'h0000);
		expect_write(2, 16'h0001);
		expect_write(9, 16'h0044);
		expect_write(5, 16'h0033);
		// 7 + -7 sets Z, 7 + 7 clears it
		new_test("addz", 16'd7);
		add_word(imm_form(LLB, 1, 8'h07));
		add_word(imm_form(LLB, 2, 8'hF9));
		add_word(reg_form(ADD, 3, 1, 2));
		add_word(reg_form(ADDZ, 4, 1, 1));
		add_word(reg_form(ADD, 5, 1, 1));
		add_word(reg_form(ADDZ, 6, 1, 2));
		add_word(imm_form(LLB, 10, 8'h01));
		expect_write(1, 16'h0007);
		expect_write(2, 16'hFFF9);
		expect_write(3, 16'h0000);
		expect_write(4, 16'h000E);
		expect_write(5, 16'h000E);
		expect_write(10, 16'h0001);
		// Word after HLT never retires
		new_test("halt", 16'd1);
		add_word(imm_form(LLB, 1, 8'h7F));
		add_word(reg_form(HLT, 0, 0, 0));
		add_word(imm_form(LLB, 2, 8'h55));
		expect_write(1, 16'h007F);
	endtask

	//////////////////////////////////////////////////
	// Compare tasks

	task automatic check_word(input string what, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_reg(input string what, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected r%0d, actual r%0d",
				cur_name, what, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_pc(input string what, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected pc %h, actual pc %h",
				cur_name, what, exp, act);
			value_errors++;
		end
	endtask

	// Drive point, 2 ns past the edge
	task automatic wait_cycle();
		@(posedge clk);
		#2;
	endtask

	// Program goes in under reset
	task automatic load_program(input int t);
		int i;
		reset = 1'b1;
		for (i = 0; i < PROG_WORDS; i++) begin
			prog_we   = 1'b1;
			prog_addr = IMEM_AW'(i);
			prog_data = prog_mem[t*PROG_WORDS + i];
			wait_cycle();
		end
		prog_we = 1'b0;
		repeat (RESET_CYCLES) wait_cycle();
		if (hlt !== 1'b0 || wb_we !== 1'b0) begin
			$display("ERROR: %s: hlt or wb_we not low during reset", cur_name);
			other_errors++;
		end
		check_pc("reset pc", '0, pc);
		reset = 1'b0;
	endtask

	task automatic run_program(input int t);
		int seen;
		int base;
		bit halted;
		seen   = 0;
		base   = t*MAX_WRITES;
		halted = 1'b0;
		while (!halted) begin
			wait_cycle();
			// Retiring writes in program order
			if (wb_we === 1'b1) begin
				if (seen < write_cnt[t]) begin
					check_reg($sformatf("write %0d dst", seen), exp_dst[base+seen], wb_dst);
					check_word($sformatf("write %0d data", seen), exp_data[base+seen], wb_data);
				end else begin
					$display("ERROR: %s: unexpected write of %h to r%0d",
						cur_name, wb_data, wb_dst);
					order_errors++;
				end
				seen++;
			end
			if (hlt === 1'b1) begin
				halted = 1'b1;
				check_pc("halt pc", exp_hlt_pc[t], pc);
			end
		end
		if (seen < write_cnt[t]) begin
			$display("ERROR: %s: halted after only %0d of %0d writes",
				cur_name, seen, write_cnt[t]);
			order_errors++;
		end
		// Pipeline frozen until the next reset
		repeat (HOLD_CYCLES) begin
			wait_cycle();
			if (hlt !== 1'b1) begin
				$display("ERROR: %s: hlt dropped before reset", cur_name);
				other_errors++;
			end
			if (wb_we !== 1'b0) begin
				$display("ERROR: %s: register write after halt", cur_name);
				order_errors++;
			end
			check_pc("frozen pc", exp_hlt_pc[t], pc);
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		int t;
		reset     = 1'b1;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		build_table();
		for (t = 0; t < num_tests; t++) begin
			cur_name = test_name[t];
			load_program(t);
			run_program(t);
		end
		$display("Summary: %0d tests, %0d value errors, %0d missing or extra writes, %0d other",
			num_tests, value_errors, order_errors, other_errors);
		if (value_errors + order_errors + other_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu #(
	parameter int IMEM_AW = 8,
	parameter int DMEM_AW = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               prog_we,
	input  logic [IMEM_AW-1:0] prog_addr,
	input  cpu_pkg::data_t     prog_data,
	output logic               hlt,
	output cpu_pkg::data_t     pc,
	output logic               wb_we,
	output cpu_pkg::reg_addr_t wb_dst,
	output cpu_pkg::data_t     wb_data
);
	import cpu_pkg::*;

	id_ex_if id_ex_bus ();
	wb_if    wb_bus ();

	instr_t    instr;
	data_t     instr_pc;
	logic      instr_valid;
	logic      stall;
	logic      bubble;
	logic      freeze;
	logic      flush;
	data_t     branch_target;
	logic      hlt_pending;
	logic      fetch_hold;
	reg_addr_t rs_num;
	reg_addr_t rt_num;
	logic      ex_is_load;
	logic      mem_we;
	reg_addr_t mem_dst;
	data_t     mem_result;
	logic      mem_is_load;
	logic      mem_is_store;
	data_t     mem_store_data;
	logic      mem_valid;
	logic      mem_hlt;
	data_t     mem_pc;

	// Retiring instruction drives the top ports
	assign hlt     = wb_bus.hlt;
	assign pc      = wb_bus.pc;
	assign wb_we   = wb_bus.we;
	assign wb_dst  = wb_bus.dst;
	assign wb_data = wb_bus.data;

	// HLT in decode parks fetch
	assign fetch_hold = stall | hlt_pending;

	// Load sitting in execute, checked against decode
	assign ex_is_load = id_ex_bus.valid && (id_ex_bus.opcode == LW);

	//////////////////////////////////////////////////
	// Pipeline stages

	fetch_unit #(.IMEM_AW(IMEM_AW)) instr_fetch (
		.clk(clk), .reset(reset),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.stall(fetch_hold), .freeze(freeze),
		.flush(flush), .branch_target(branch_target),
		.instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid)
	);

	decode instr_decode (
		.clk(clk), .reset(reset),
		.instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid),
		.bubble(bubble), .flush(flush), .stall(stall), .freeze(freeze),
		.wb(wb_bus.sink), .ex(id_ex_bus.producer),
		.hlt_pending(hlt_pending), .rs_num(rs_num), .rt_num(rt_num)
	);

	execute execution (
		.clk(clk), .reset(reset), .freeze(freeze),
		.ex(id_ex_bus.consumer), .wb(wb_bus.sink),
		.mem_we(mem_we), .mem_dst(mem_dst), .mem_result(mem_result),
		.mem_is_load(mem_is_load), .mem_is_store(mem_is_store),
		.mem_store_data(mem_store_data), .mem_valid(mem_valid),
		.mem_hlt(mem_hlt), .mem_pc(mem_pc),
		.flush(flush), .branch_target(branch_target)
	);

	mem_stage #(.DMEM_AW(DMEM_AW)) memory (
		.clk(clk), .reset(reset), .freeze(freeze),
		.mem_we(mem_we), .mem_dst(mem_dst), .mem_result(mem_result),
		.mem_is_load(mem_is_load), .mem_is_store(mem_is_store),
		.mem_store_data(mem_store_data), .mem_valid(mem_valid),
		.mem_hlt(mem_hlt), .mem_pc(mem_pc),
		.wb(wb_bus.source)
	);

	// Stall, bubble and halt control
	hazard_fsm hazard_unit (
		.clk(clk), .reset(reset),
		.mem_is_load(ex_is_load), .mem_dst(id_ex_bus.dst),
		.rs_num(rs_num), .rt_num(rt_num), .wb_hlt(wb_bus.hlt),
		.stall(stall), .bubble(bubble), .freeze(freeze)
	);

endmodule

`default_nettype wire

// File: src/hazard_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_fsm (
	input  logic               clk,
	input  logic               reset,
	input  logic               mem_is_load,
	input  cpu_pkg::reg_addr_t mem_dst,
	input  cpu_pkg::reg_addr_t rs_num,
	input  cpu_pkg::reg_addr_t rt_num,
	input  logic               wb_hlt,
	output logic               stall,
	output logic               bubble,
	output logic               freeze
);
	import cpu_pkg::*;

	hz_state_e state;
	hz_state_e state_next;
	logic      load_use;

	// Load in execute, its target read in decode
	assign load_use = mem_is_load && (mem_dst == rs_num || mem_dst == rt_num);

	always_ff @(posedge clk) begin
		if (reset)
			state <= RUN;
		else
			state <= state_next;
	end

	// Stall is raised on the way into LOAD_STALL
	// so the consumer never leaves decode
	always_comb begin
		state_next = state;
		stall      = 1'b0;
		bubble     = 1'b0;
		freeze     = 1'b0;
		case (state)
			RUN: begin
				if (wb_hlt) begin
					state_next = HALTED;
					freeze     = 1'b1;
				end else if (load_use) begin
					state_next = LOAD_STALL;
					stall      = 1'b1;
					bubble     = 1'b1;
				end
			end
			LOAD_STALL: begin
				state_next = wb_hlt ? HALTED : RUN;
				freeze     = wb_hlt;
			end
			// Only reset leaves this
			HALTED: freeze = 1'b1;
			default: state_next = RUN;
		endcase
	end

endmodule

`default_nettype wire

// File: src/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage #(
	parameter int DMEM_AW = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               freeze,
	input  logic               mem_we,
	input  cpu_pkg::reg_addr_t mem_dst,
	input  cpu_pkg::data_t     mem_result,
	input  logic               mem_is_load,
	input  logic               mem_is_store,
	input  cpu_pkg::data_t     mem_store_data,
	input  logic               mem_valid,
	input  logic               mem_hlt,
	input  cpu_pkg::data_t     mem_pc,
	wb_if.source               wb
);
	import cpu_pkg::*;

	data_t dmem [2**DMEM_AW];
	data_t load_data;

	// Address is the ALU sum, low bits only
	assign load_data = dmem[mem_result[DMEM_AW-1:0]];

	always_ff @(posedge clk) begin
		if (!freeze && mem_is_store)
			dmem[mem_result[DMEM_AW-1:0]] <= mem_store_data;
	end

	//////////////////////////////////////////////////
	// MEM/WB register

	always_ff @(posedge clk) begin
		if (reset) begin
			wb.valid <= 1'b0;
			wb.we    <= 1'b0;
			wb.hlt   <= 1'b0;
			wb.pc    <= '0;
		end else if (!freeze) begin
			wb.valid <= mem_valid;
			wb.we    <= mem_we;
			wb.hlt   <= mem_hlt;
			wb.pc    <= mem_pc;
		end
	end

	// Load data or ALU result
	always_ff @(posedge clk) begin
		if (!freeze) begin
			wb.dst  <= mem_dst;
			wb.data <= mem_is_load ? load_data : mem_result;
		end
	end

endmodule

`default_nettype wire

// File: execute/execute.sv
`timescale 1ns/100ps
`default_nettype none

module execute (
	input  logic               clk,
	input  logic               reset,
	input  logic               freeze,
	id_ex_if.consumer          ex,
	wb_if.sink                 wb,
	output logic               mem_we,
	output cpu_pkg::reg_addr_t mem_dst,
	output cpu_pkg::data_t     mem_result,
	output logic               mem_is_load,
	output logic               mem_is_store,
	output cpu_pkg::data_t     mem_store_data,
	output logic               mem_valid,
	output logic               mem_hlt,
	output cpu_pkg::data_t     mem_pc,
	output logic               flush,
	output cpu_pkg::data_t     branch_target
);
	import cpu_pkg::*;

	logic  fwd_mem_a;
	logic  fwd_mem_b;
	logic  fwd_wb_a;
	logic  fwd_wb_b;
	data_t op_a;
	data_t op_b;
	data_t alu_out;
	logic  zero_flag;
	logic  updates_flag;
	logic  write_en;

	//////////////////////////////////////////////////
	// Operand forwarding

	// Load data is not ready in memory stage
	assign fwd_mem_a = mem_we && !mem_is_load && (mem_dst == ex.rs);
	assign fwd_mem_b = mem_we && !mem_is_load && (mem_dst == ex.rt);
	assign fwd_wb_a  = wb.valid && wb.we && (wb.dst == ex.rs);
	assign fwd_wb_b  = wb.valid && wb.we && (wb.dst == ex.rt);

	assign op_a = fwd_mem_a ? mem_result : (fwd_wb_a ? wb.data : ex.rs_val);
	assign op_b = fwd_mem_b ? mem_result : (fwd_wb_b ? wb.data : ex.rt_val);

	// ALU
	always_comb begin
		case (ex.opcode)
			SUB:     alu_out = op_a - op_b;
			AND:     alu_out = op_a & op_b;
			LLB:     alu_out = ex.imm;
			LW, SW:  alu_out = op_a + ex.imm;
			default: alu_out = op_a + op_b;
		endcase
	end

	// Zero flag, set by arithmetic and logic ops only
	assign updates_flag = ex.valid && (ex.opcode inside {ADD, SUB, AND});

	always_ff @(posedge clk) begin
		if (reset)
			zero_flag <= 1'b0;
		else if (!freeze && updates_flag)
			zero_flag <= (alu_out == '0);
	end

	// ADDZ drops its write unless Z is set
	assign write_en = ex.we && !(ex.opcode == ADDZ && !zero_flag);

	// Branch resolves here, tested register in op_a
	assign flush         = ex.valid && (ex.opcode == BEQZ) && (op_a == '0);
	assign branch_target = ex.pc + 16'd1 + ex.imm;

	//////////////////////////////////////////////////
	// EX/MEM register

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_valid    <= 1'b0;
			mem_we       <= 1'b0;
			mem_is_load  <= 1'b0;
			mem_is_store <= 1'b0;
			mem_hlt      <= 1'b0;
		end else if (!freeze) begin
			mem_valid    <= ex.valid;
			mem_we       <= ex.valid && write_en;
			mem_is_load  <= ex.valid && (ex.opcode == LW);
			mem_is_store <= ex.valid && (ex.opcode == SW);
			mem_hlt      <= ex.valid && (ex.opcode == HLT);
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			mem_dst        <= ex.dst;
			mem_result     <= alu_out;
			mem_store_data <= op_b;
			mem_pc         <= ex.pc;
		end
	end

endmodule

`default_nettype wire

// File: decode/decode.sv
`timescale 1ns/100ps
`default_nettype none

module decode (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::instr_t    instr,
	input  cpu_pkg::data_t     instr_pc,
	input  logic               instr_valid,
	input  logic               bubble,
	input  logic               flush,
	input  logic               stall,
	input  logic               freeze,
	wb_if.sink                 wb,
	id_ex_if.producer          ex,
	output logic               hlt_pending,
	output cpu_pkg::reg_addr_t rs_num,
	output cpu_pkg::reg_addr_t rt_num
);
	import cpu_pkg::*;

	data_t     regs [16];
	reg_addr_t rs_sel;
	reg_addr_t rt_sel;
	logic      we_sel;
	data_t     imm_sel;
	logic      wb_write;
	data_t     rs_val;
	data_t     rt_val;

	//////////////////////////////////////////////////
	// Field selection per opcode

	always_comb begin
		rs_sel  = instr.r.rs;
		rt_sel  = instr.r.rt;
		we_sel  = 1'b0;
		// Signed imm8 for LLB and BEQZ
		imm_sel = {{8{instr.i.imm8[7]}}, instr.i.imm8};
		case (instr.r.opcode)
			ADD, ADDZ, SUB, AND, LLB: we_sel = 1'b1;
			LW: begin
				// rt field is the offset here
				rt_sel  = instr.r.rs;
				we_sel  = 1'b1;
				imm_sel = {12'd0, instr.r.rt};
			end
			SW: begin
				// Store data comes from rd
				rt_sel  = instr.r.rd;
				imm_sel = {12'd0, instr.r.rt};
			end
			BEQZ: begin
				rs_sel = instr.r.rd;
				rt_sel = instr.r.rd;
			end
			default: ;
		endcase
	end

	// Register file
	assign wb_write = wb.valid && wb.we;

	always_ff @(posedge clk) begin
		if (wb_write)
			regs[wb.dst] <= wb.data;
	end

	// Same-cycle writeback passes straight through
	assign rs_val = (wb_write && wb.dst == rs_sel) ? wb.data : regs[rs_sel];
	assign rt_val = (wb_write && wb.dst == rt_sel) ? wb.data : regs[rt_sel];

	assign hlt_pending = instr_valid && (instr.r.opcode == HLT);
	assign rs_num      = rs_sel;
	assign rt_num      = rt_sel;

	//////////////////////////////////////////////////
	// ID/EX register

	always_ff @(posedge clk) begin
		if (reset)
			ex.valid <= 1'b0;
		else if (!freeze) begin
			if (flush || bubble)
				ex.valid <= 1'b0;
			else if (!stall)
				ex.valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze && !stall) begin
			ex.opcode <= instr.r.opcode;
			ex.rs     <= rs_sel;
			ex.rt     <= rt_sel;
			ex.rs_val <= rs_val;
			ex.rt_val <= rt_val;
			ex.dst    <= instr.r.rd;
			ex.we     <= we_sel;
			ex.imm    <= imm_sel;
			ex.pc     <= instr_pc;
		end
	end

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
	parameter int IMEM_AW = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               prog_we,
	input  logic [IMEM_AW-1:0] prog_addr,
	input  cpu_pkg::data_t     prog_data,
	input  logic               stall,
	input  logic               freeze,
	input  logic               flush,
	input  cpu_pkg::data_t     branch_target,
	output cpu_pkg::instr_t    instr,
	output cpu_pkg::data_t     instr_pc,
	output logic               instr_valid
);
	import cpu_pkg::*;

	data_t imem [2**IMEM_AW];
	data_t fetch_pc;

	// Program load port, usable during reset
	always_ff @(posedge clk) begin
		if (prog_we)
			imem[prog_addr] <= prog_data;
	end

	// PC counter
	// Branch redirect beats the hold
	always_ff @(posedge clk) begin
		if (reset)
			fetch_pc <= '0;
		else if (!freeze) begin
			if (flush)
				fetch_pc <= branch_target;
			else if (!stall)
				fetch_pc <= fetch_pc + 16'd1;
		end
	end

	//////////////////////////////////////////////////
	// IF/ID register

	always_ff @(posedge clk) begin
		if (reset)
			instr_valid <= 1'b0;
		else if (!freeze) begin
			if (flush)
				instr_valid <= 1'b0;
			else if (!stall)
				instr_valid <= 1'b1;
		end
	end

	// Held word stays in decode
	always_ff @(posedge clk) begin
		if (!freeze && !stall) begin
			instr    <= imem[fetch_pc[IMEM_AW-1:0]];
			instr_pc <= fetch_pc;
		end
	end

endmodule

`default_nettype wire

// File: common/wb_if.sv
`timescale 1ns/100ps
`default_nettype none

// Retiring instruction in writeback
interface wb_if;
	import cpu_pkg::*;

	logic      valid;
	logic      we;
	reg_addr_t dst;
	data_t     data;
	logic      hlt;
	data_t     pc;

	modport source (output valid, we, dst, data, hlt, pc);
	modport sink (input valid, we, dst, data, hlt, pc);
endinterface

`default_nettype wire

// File: common/id_ex_if.sv
`timescale 1ns/100ps
`default_nettype none

// Decoded instruction headed into execute
interface id_ex_if;
	import cpu_pkg::*;

	logic      valid;
	opcode_e   opcode;
	reg_addr_t rs;
	reg_addr_t rt;
	data_t     rs_val;
	data_t     rt_val;
	reg_addr_t dst;
	logic      we;
	// Already sign or zero extended
	data_t     imm;
	data_t     pc;

	modport producer (output valid, opcode, rs, rt, rs_val, rt_val, dst, we, imm, pc);
	modport consumer (input valid, opcode, rs, rt, rs_val, rt_val, dst, we, imm, pc);
endinterface

`default_nettype wire

// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Machine word for registers, ALU, memories and pc
	typedef logic [15:0] data_t;

	// One of sixteen registers
	typedef logic [3:0] reg_addr_t;

	// Top nibble of every instruction
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		ADDZ = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		LW   = 4'd8,
		SW   = 4'd9,
		LLB  = 4'd10,
		BEQZ = 4'd12,
		HLT  = 4'd15
	} opcode_e;

	// Three register fields
	typedef struct packed {
		opcode_e   opcode;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
	} reg_view_t;

	// Register plus 8-bit immediate
	typedef struct packed {
		opcode_e    opcode;
		reg_addr_t  rd;
		logic [7:0] imm8;
	} imm_view_t;

	// Same word, decoded either way
	typedef union packed {
		reg_view_t r;
		imm_view_t i;
	} instr_t;

	// Hazard controller states
	typedef enum logic [1:0] {
		RUN,
		LOAD_STALL,
		HALTED
	} hz_state_e;

endpackage

`default_nettype wire
